//--- include/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// data path and pc width
`define DECODE_DATA_W 32

// general register address width
`define DECODE_REG_AW 5

// number of general registers
`define DECODE_REG_NUM 32

// one-hot alu operation
`define DECODE_ALU_OP_W 12

// one-hot conditional branch operation
`define DECODE_BR_OP_W 6

`endif

//--- hdl/decode_pkg.sv
`include "decode_macros.svh"

package decode_pkg;

    // stage slots in the stall and forward arrays
    localparam int STAGE_ES = 0;
    localparam int STAGE_MS = 1;
    localparam int STAGE_WS = 2;

    // bit positions of the one-hot branch operation
    localparam int BR_BEQ  = 0;
    localparam int BR_BNE  = 1;
    localparam int BR_BGEZ = 2;
    localparam int BR_BGTZ = 3;
    localparam int BR_BLEZ = 4;
    localparam int BR_BLTZ = 5;

    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] sa;
        logic [5:0] func;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] jidx;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        instr_u                    inst;
        logic [`DECODE_DATA_W-1:0] pc;
    } fs_to_ds_t;

    typedef struct packed {
        logic                        hl_from_rs;
        logic [`DECODE_ALU_OP_W-1:0] alu_op;
        logic [1:0]                  mul_op;
        logic [1:0]                  div_op;
        logic                        load_op;
        logic                        src1_is_sa;
        logic                        src1_is_pc;
        logic                        src1_is_hi;
        logic                        src1_is_lo;
        logic                        src2_is_imm;
        logic                        src2_is_uimm;
        logic                        src2_is_8;
        logic                        gr_we;
        logic                        hi_we;
        logic                        lo_we;
        logic                        mem_we;
        logic [`DECODE_REG_AW-1:0]   dest;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [15:0]               imm;
        logic [`DECODE_DATA_W-1:0] rs_value;
        logic [`DECODE_DATA_W-1:0] rt_value;
        logic [`DECODE_DATA_W-1:0] pc;
    } ds_to_es_t;

    typedef struct packed {
        logic                      taken;
        logic [`DECODE_DATA_W-1:0] target;
    } br_bus_t;

    typedef struct packed {
        logic                      we;
        logic [`DECODE_REG_AW-1:0] waddr;
        logic [`DECODE_DATA_W-1:0] wdata;
    } rf_wr_t;

    typedef struct packed {
        logic                      we;
        logic [`DECODE_REG_AW-1:0] dest;
    } stall_src_t;

    typedef struct packed {
        logic                      valid;
        logic [`DECODE_DATA_W-1:0] data;
    } fwd_src_t;

    typedef struct packed {
        logic rs;
        logic rt;
    } src_use_t;

endpackage

//--- hdl/regfile.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module regfile import decode_pkg::*; (
    input  logic                      clk,
    input  logic [`DECODE_REG_AW-1:0] raddr1,
    input  logic [`DECODE_REG_AW-1:0] raddr2,
    output logic [`DECODE_DATA_W-1:0] rdata1,
    output logic [`DECODE_DATA_W-1:0] rdata2,
    input  rf_wr_t                    wr
);

    logic [`DECODE_DATA_W-1:0] regs [`DECODE_REG_NUM];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // no write bypass, a write shows up on the following cycle
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module instr_decoder import decode_pkg::*; (
    input  instr_u                     inst,
    output ctrl_t                      ctrl,
    output src_use_t                   src_use,
    output logic [`DECODE_BR_OP_W-1:0] br_op,
    output logic                       is_jump_imm,
    output logic                       is_jump_reg
);

    logic [5:0] op;
    logic [5:0] func;
    logic [4:0] rt;
    logic       special, regimm, r3, rs_z, rt_z, rd_z;
    logic       inst_add, inst_addi, inst_addu, inst_addiu, inst_sub, inst_subu;
    logic       inst_slt, inst_slti, inst_sltu, inst_sltiu;
    logic       inst_and, inst_andi, inst_or, inst_ori, inst_xor, inst_xori, inst_nor;
    logic       inst_sll, inst_sllv, inst_srl, inst_srlv, inst_sra, inst_srav;
    logic       inst_mult, inst_multu, inst_div, inst_divu;
    logic       inst_mfhi, inst_mflo, inst_mthi, inst_mtlo;
    logic       inst_lui, inst_lw, inst_sw;
    logic       inst_beq, inst_bne, inst_bgez, inst_bgtz, inst_blez, inst_bltz;
    logic       inst_bgezal, inst_bltzal, inst_j, inst_jal, inst_jr, inst_jalr;
    logic       dst_is_r31, dst_is_rt;

    assign op      = inst.r_fmt.op;
    assign func    = inst.r_fmt.func;
    assign rt      = inst.i_fmt.rt;
    assign special = (op == 6'h00);
    assign regimm  = (op == 6'h01);
    assign rs_z    = (inst.r_fmt.rs == 5'd0);
    assign rt_z    = (rt == 5'd0);
    assign rd_z    = (inst.r_fmt.rd == 5'd0);
    // register-register forms need sa clear
    assign r3      = special && (inst.r_fmt.sa == 5'd0);

    assign inst_add    = r3 && func == 6'h20;
    assign inst_addu   = r3 && func == 6'h21;
    assign inst_sub    = r3 && func == 6'h22;
    assign inst_subu   = r3 && func == 6'h23;
    assign inst_and    = r3 && func == 6'h24;
    assign inst_or     = r3 && func == 6'h25;
    assign inst_xor    = r3 && func == 6'h26;
    assign inst_nor    = r3 && func == 6'h27;
    assign inst_slt    = r3 && func == 6'h2a;
    assign inst_sltu   = r3 && func == 6'h2b;
    assign inst_sllv   = r3 && func == 6'h04;
    assign inst_srlv   = r3 && func == 6'h06;
    assign inst_srav   = r3 && func == 6'h07;
    assign inst_sll    = special && rs_z && func == 6'h00;
    assign inst_srl    = special && rs_z && func == 6'h02;
    assign inst_sra    = special && rs_z && func == 6'h03;
    assign inst_mult   = r3 && rd_z && func == 6'h18;
    assign inst_multu  = r3 && rd_z && func == 6'h19;
    assign inst_div    = r3 && rd_z && func == 6'h1a;
    assign inst_divu   = r3 && rd_z && func == 6'h1b;
    assign inst_mfhi   = r3 && rs_z && rt_z && func == 6'h10;
    assign inst_mflo   = r3 && rs_z && rt_z && func == 6'h12;
    assign inst_mthi   = r3 && rt_z && rd_z && func == 6'h11;
    assign inst_mtlo   = r3 && rt_z && rd_z && func == 6'h13;
    assign inst_jr     = r3 && rt_z && rd_z && func == 6'h08;
    assign inst_jalr   = r3 && rt_z && func == 6'h09;
    assign inst_addi   = (op == 6'h08);
    assign inst_addiu  = (op == 6'h09);
    assign inst_slti   = (op == 6'h0a);
    assign inst_sltiu  = (op == 6'h0b);
    assign inst_andi   = (op == 6'h0c);
    assign inst_ori    = (op == 6'h0d);
    assign inst_xori   = (op == 6'h0e);
    assign inst_lui    = (op == 6'h0f) && rs_z;
    assign inst_lw     = (op == 6'h23);
    assign inst_sw     = (op == 6'h2b);
    assign inst_beq    = (op == 6'h04);
    assign inst_bne    = (op == 6'h05);
    assign inst_blez   = (op == 6'h06) && rt_z;
    assign inst_bgtz   = (op == 6'h07) && rt_z;
    assign inst_bltz   = regimm && rt == 5'h00;
    assign inst_bgez   = regimm && rt == 5'h01;
    assign inst_bltzal = regimm && rt == 5'h10;
    assign inst_bgezal = regimm && rt == 5'h11;
    assign inst_j      = (op == 6'h02);
    assign inst_jal    = (op == 6'h03);

    // link forms compute pc + 8 through the adder
    assign ctrl.alu_op[0]  = inst_add | inst_addi | inst_addu | inst_addiu | inst_lw
                           | inst_sw | inst_jal | inst_jalr | inst_bgezal | inst_bltzal;
    assign ctrl.alu_op[1]  = inst_sub | inst_subu;
    assign ctrl.alu_op[2]  = inst_slt | inst_slti;
    assign ctrl.alu_op[3]  = inst_sltu | inst_sltiu;
    assign ctrl.alu_op[4]  = inst_and | inst_andi;
    assign ctrl.alu_op[5]  = inst_nor;
    assign ctrl.alu_op[6]  = inst_or | inst_ori | inst_mfhi | inst_mflo;
    assign ctrl.alu_op[7]  = inst_xor | inst_xori;
    assign ctrl.alu_op[8]  = inst_sll | inst_sllv;
    assign ctrl.alu_op[9]  = inst_srl | inst_srlv;
    assign ctrl.alu_op[10] = inst_sra | inst_srav;
    assign ctrl.alu_op[11] = inst_lui;
    assign ctrl.mul_op     = {inst_multu, inst_mult};
    assign ctrl.div_op     = {inst_divu, inst_div};
    assign ctrl.load_op    = inst_lw;

    assign ctrl.src1_is_sa   = inst_sll | inst_srl | inst_sra;
    assign ctrl.src1_is_pc   = inst_jal | inst_jalr | inst_bgezal | inst_bltzal;
    assign ctrl.src1_is_hi   = inst_mfhi;
    assign ctrl.src1_is_lo   = inst_mflo;
    assign ctrl.src2_is_imm  = inst_addi | inst_addiu | inst_slti | inst_sltiu
                             | inst_lui | inst_lw | inst_sw;
    assign ctrl.src2_is_uimm = inst_andi | inst_ori | inst_xori;
    assign ctrl.src2_is_8    = ctrl.src1_is_pc;

    assign ctrl.gr_we      = ~(inst_beq | inst_bne | inst_bgez | inst_bgtz | inst_blez
                             | inst_bltz | inst_sw | inst_j | inst_jr | inst_mthi | inst_mtlo);
    assign ctrl.hi_we      = inst_mult | inst_multu | inst_div | inst_divu | inst_mthi;
    assign ctrl.lo_we      = inst_mult | inst_multu | inst_div | inst_divu | inst_mtlo;
    assign ctrl.hl_from_rs = inst_mthi | inst_mtlo;
    assign ctrl.mem_we     = inst_sw;

    assign dst_is_r31 = inst_jal | inst_bgezal | inst_bltzal;
    assign dst_is_rt  = ctrl.src2_is_imm & ~inst_sw | ctrl.src2_is_uimm;
    assign ctrl.dest  = dst_is_r31 ? 5'd31 : (dst_is_rt ? rt : inst.r_fmt.rd);

    // which source fields are real operands
    assign src_use.rs = ~ctrl.src1_is_sa & ~ctrl.src1_is_pc;
    assign src_use.rt = (~(ctrl.src2_is_imm | ctrl.src2_is_uimm) | inst_sw) & ~ctrl.src2_is_8;

    assign br_op[BR_BEQ]  = inst_beq;
    assign br_op[BR_BNE]  = inst_bne;
    assign br_op[BR_BGEZ] = inst_bgez | inst_bgezal;
    assign br_op[BR_BGTZ] = inst_bgtz;
    assign br_op[BR_BLEZ] = inst_blez;
    assign br_op[BR_BLTZ] = inst_bltz | inst_bltzal;
    assign is_jump_imm    = inst_j | inst_jal;
    assign is_jump_reg    = inst_jr | inst_jalr;

    a_alu_op_onehot: assert final ($onehot0(ctrl.alu_op))
        else $error("alu_op has more than one bit set");

endmodule

//--- hdl/hazard_unit.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module hazard_unit import decode_pkg::*; (
    input  logic [`DECODE_REG_AW-1:0] rs,
    input  logic [`DECODE_REG_AW-1:0] rt,
    input  src_use_t                  src_use,
    input  logic [`DECODE_DATA_W-1:0] rf_rdata1,
    input  logic [`DECODE_DATA_W-1:0] rf_rdata2,
    input  stall_src_t [0:2]          stall_srcs,
    input  fwd_src_t [0:2]            fwd_srcs,
    output logic [`DECODE_DATA_W-1:0] rs_value,
    output logic [`DECODE_DATA_W-1:0] rt_value,
    output logic                      ready_go
);

    // index 0 is rs, index 1 is rt
    logic [1:0][`DECODE_REG_AW-1:0] src_addr;
    logic [1:0][`DECODE_DATA_W-1:0] rf_data;
    logic [1:0][`DECODE_DATA_W-1:0] value;
    logic [1:0][2:0]                hit;
    logic [1:0][2:0]                fwd_sel;
    logic [1:0]                     src_used;
    logic [1:0]                     src_stall;

    assign src_addr = {rt, rs};
    assign rf_data  = {rf_rdata2, rf_rdata1};
    assign src_used = {src_use.rt, src_use.rs};

    for (genvar s = 0; s < 2; s++) begin : g_src
        for (genvar k = 0; k < 3; k++) begin : g_stage
            assign hit[s][k] = src_used[s] && src_addr[s] != '0 && stall_srcs[k].we
                             && stall_srcs[k].dest == src_addr[s];
        end

        // only the nearest matching stage may supply the value
        assign fwd_sel[s][STAGE_ES] = hit[s][STAGE_ES] && fwd_srcs[STAGE_ES].valid;
        assign fwd_sel[s][STAGE_MS] = hit[s][STAGE_MS] && !hit[s][STAGE_ES]
                                    && fwd_srcs[STAGE_MS].valid;
        assign fwd_sel[s][STAGE_WS] = hit[s][STAGE_WS] && !hit[s][STAGE_ES]
                                    && !hit[s][STAGE_MS] && fwd_srcs[STAGE_WS].valid;
        assign src_stall[s] = (|hit[s]) && !(|fwd_sel[s]);

        always_comb begin
            value[s] = rf_data[s];
            for (int k = 0; k < 3; k++) begin
                if (fwd_sel[s][k]) begin
                    value[s] = fwd_srcs[k].data;
                end
            end
        end

        a_fwd_sel_onehot: assert final ($onehot0(fwd_sel[s]))
            else $error("more than one forward select for source %0d", s);
    end

    assign rs_value = value[0];
    assign rt_value = value[1];
    assign ready_go = !(|src_stall);

endmodule

//--- hdl/branch_compare.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module branch_compare import decode_pkg::*; (
    input  logic [`DECODE_BR_OP_W-1:0] br_op,
    input  logic [`DECODE_DATA_W-1:0]  src1,
    input  logic [`DECODE_DATA_W-1:0]  src2,
    output logic                       cond_true
);

    logic equal;
    logic negative;
    logic zero;

    assign equal    = (src1 == src2);
    // sign bit of rs decides the compare-with-zero tests
    assign negative = $signed(src1) < 0;
    assign zero     = (src1 == '0);

    assign cond_true = (br_op[BR_BEQ] && equal)
                     || (br_op[BR_BNE] && !equal)
                     || (br_op[BR_BGEZ] && !negative)
                     || (br_op[BR_BGTZ] && !negative && !zero)
                     || (br_op[BR_BLEZ] && (negative || zero))
                     || (br_op[BR_BLTZ] && negative);

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module id_stage import decode_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             fs_to_ds_valid,
    input  fs_to_ds_t        fs_to_ds,
    output logic             ds_allowin,
    input  logic             es_allowin,
    output logic             ds_to_es_valid,
    output ds_to_es_t        ds_to_es,
    output br_bus_t          br_bus,
    input  rf_wr_t           rf_wr,
    input  stall_src_t [0:2] stall_srcs,
    input  fwd_src_t [0:2]   fwd_srcs
);

    logic                       ds_valid;
    logic                       ds_ready_go;
    fs_to_ds_t                  ds_r;
    ctrl_t                      ctrl;
    src_use_t                   src_use;
    logic [`DECODE_BR_OP_W-1:0] br_op;
    logic                       is_jump_imm;
    logic                       is_jump_reg;
    logic                       cond_true;
    logic [`DECODE_DATA_W-1:0]  rf_rdata1;
    logic [`DECODE_DATA_W-1:0]  rf_rdata2;
    logic [`DECODE_DATA_W-1:0]  rs_value;
    logic [`DECODE_DATA_W-1:0]  rt_value;
    logic [`DECODE_DATA_W-1:0]  br_offset;

    assign ds_allowin     = !ds_valid || (ds_ready_go && es_allowin);
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_r <= fs_to_ds;
        end
    end

    instr_decoder instr_decoder_inst (
        .inst        (ds_r.inst),
        .ctrl        (ctrl),
        .src_use     (src_use),
        .br_op       (br_op),
        .is_jump_imm (is_jump_imm),
        .is_jump_reg (is_jump_reg)
    );

    regfile regfile_inst (
        .clk    (clk),
        .raddr1 (ds_r.inst.r_fmt.rs),
        .raddr2 (ds_r.inst.r_fmt.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_wr)
    );

    hazard_unit hazard_unit_inst (
        .rs         (ds_r.inst.r_fmt.rs),
        .rt         (ds_r.inst.r_fmt.rt),
        .src_use    (src_use),
        .rf_rdata1  (rf_rdata1),
        .rf_rdata2  (rf_rdata2),
        .stall_srcs (stall_srcs),
        .fwd_srcs   (fwd_srcs),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .ready_go   (ds_ready_go)
    );

    branch_compare branch_compare_inst (
        .br_op     (br_op),
        .src1      (rs_value),
        .src2      (rt_value),
        .cond_true (cond_true)
    );

    // targets are relative to the delay slot pc now in fetch
    assign br_offset = {{14{ds_r.inst.i_fmt.imm[15]}}, ds_r.inst.i_fmt.imm, 2'b00};

    always_comb begin
        if (|br_op) begin
            br_bus.target = fs_to_ds.pc + br_offset;
        end else if (is_jump_reg) begin
            br_bus.target = rs_value;
        end else begin
            br_bus.target = {fs_to_ds.pc[31:28], ds_r.inst.j_fmt.jidx, 2'b00};
        end
    end

    assign br_bus.taken = (cond_true || is_jump_imm || is_jump_reg) && ds_valid;

    assign ds_to_es.ctrl     = ctrl;
    assign ds_to_es.imm      = ds_r.inst.i_fmt.imm;
    assign ds_to_es.rs_value = rs_value;
    assign ds_to_es.rt_value = rt_value;
    assign ds_to_es.pc       = ds_r.pc;

    a_allowin_when_empty: assert property (
        @(posedge clk) disable iff (reset) !ds_valid |-> ds_allowin
    ) else $error("decode stage empty but not accepting");

    a_out_valid_needs_valid: assert property (
        @(posedge clk) disable iff (reset) ds_to_es_valid |-> ds_valid
    ) else $error("ds_to_es_valid raised without a held instruction");

endmodule

//--- verif/tb_id_stage.sv
`timescale 1ns/1ps
`include "decode_macros.svh"

module tb_id_stage import decode_pkg::*; ();

    // reset, register init, plain, hazard, branch and back-pressure sections
    localparam int STIM_CYCLES = 8 + 33 + 12 * 4 + 7 * 8 + 36 * 4 + 8;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES;

    typedef struct packed {
        logic        chk;
        logic        use_rs;
        logic        use_rt;
        logic [4:0]  dest;
        logic [11:0] alu_op;
        logic        load_op;
        logic        mem_we;
    } exp_dec_t;

    logic             clk = 1'b0;
    logic             reset;
    logic             fs_to_ds_valid;
    fs_to_ds_t        fs_to_ds;
    logic             ds_allowin;
    logic             es_allowin;
    logic             ds_to_es_valid;
    ds_to_es_t        ds_to_es;
    br_bus_t          br_bus;
    rf_wr_t           rf_wr;
    stall_src_t [0:2] stall_srcs;
    fwd_src_t [0:2]   fwd_srcs;

    // reference model of the stage
    logic [31:0]      shadow [32];
    logic             held_valid;
    fs_to_ds_t        held;
    exp_dec_t         dec;
    logic [1:0][31:0] exp_val;
    logic [1:0]       src_stall;
    logic             exp_ready, exp_allowin, exp_out_valid, exp_taken;
    logic [31:0]      exp_target;
    int               cycle = 0;
    int               errors = 0;
    int               accepted = 0;
    int               delivered = 0;
    logic [31:0]      rng_state = 32'd65;

    id_stage id_stage_inst (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    function automatic logic [4:0] rnd_reg();
        return 5'(next_rand());
    endfunction

    function automatic logic [31:0] r_type(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                           logic [4:0] sa, logic [5:0] func);
        return {6'h00, rs, rt, rd, sa, func};
    endfunction

    function automatic logic [31:0] i_type(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic exp_dec_t decode_expect(logic [31:0] w);
        exp_dec_t   d;
        logic [5:0] op;
        logic [5:0] func;
        logic       link;
        op = w[31:26];
        func = w[5:0];
        d = '0;
        d.chk = 1'b1;
        d.dest = w[15:11];
        // jal, jalr, bltzal, bgezal
        link = op == 6'h03 || (op == 6'h00 && func == 6'h09) || (op == 6'h01 && w[20]);
        d.use_rs = !link && !(op == 6'h00 && func == 6'h00);
        d.use_rt = !link && !(op inside {6'h09, 6'h0f, 6'h23});
        case (op)
            6'h00: begin
                case (func)
                    6'h21, 6'h09: d.alu_op[0] = 1'b1;
                    6'h00: d.alu_op[8] = 1'b1;
                    6'h10: d.alu_op[6] = 1'b1;
                    6'h18: d.alu_op = '0;
                    default: d.chk = 1'b0;
                endcase
            end
            6'h09, 6'h23: begin
                d.alu_op[0] = 1'b1;
                d.dest = w[20:16];
                d.load_op = (op == 6'h23);
            end
            6'h2b: begin
                d.alu_op[0] = 1'b1;
                d.mem_we = 1'b1;
            end
            6'h0f: begin
                d.alu_op[11] = 1'b1;
                d.dest = w[20:16];
            end
            6'h03: begin
                d.alu_op[0] = 1'b1;
                d.dest = 5'd31;
            end
            default: d.chk = 1'b0;
        endcase
        return d;
    endfunction

    always_comb begin
        logic [1:0][4:0] addr;
        logic [1:0]      used;
        logic            found;
        logic [5:0]      op;
        dec = decode_expect(held.inst);
        addr = {held.inst.i_fmt.rt, held.inst.i_fmt.rs};
        used = {dec.use_rt, dec.use_rs};
        for (int s = 0; s < 2; s++) begin
            exp_val[s] = shadow[addr[s]];
            src_stall[s] = 1'b0;
            found = 1'b0;
            // nearest writer wins
            for (int k = 0; k < 3; k++) begin
                if (!found && used[s] && addr[s] != 0 && stall_srcs[k].we
                        && stall_srcs[k].dest == addr[s]) begin
                    found = 1'b1;
                    if (fwd_srcs[k].valid) begin
                        exp_val[s] = fwd_srcs[k].data;
                    end else begin
                        src_stall[s] = 1'b1;
                    end
                end
            end
        end
        exp_ready = !(|src_stall);
        exp_allowin = !held_valid || (exp_ready && es_allowin);
        exp_out_valid = held_valid && exp_ready;
        op = held.inst.r_fmt.op;
        case (op)
            6'h04: exp_taken = exp_val[0] == exp_val[1];
            6'h05: exp_taken = exp_val[0] != exp_val[1];
            6'h06: exp_taken = $signed(exp_val[0]) <= 0;
            6'h07: exp_taken = $signed(exp_val[0]) > 0;
            6'h01: exp_taken = held.inst.i_fmt.rt[0] ? $signed(exp_val[0]) >= 0
                                                     : $signed(exp_val[0]) < 0;
            6'h02, 6'h03: exp_taken = 1'b1;
            6'h00: exp_taken = held.inst.r_fmt.func inside {6'h08, 6'h09};
            default: exp_taken = 1'b0;
        endcase
        if (op inside {6'h01, 6'h04, 6'h05, 6'h06, 6'h07}) begin
            exp_target = fs_to_ds.pc + {{14{held.inst.i_fmt.imm[15]}}, held.inst.i_fmt.imm, 2'b00};
        end else if (op == 6'h00) begin
            exp_target = exp_val[0];
        end else begin
            exp_target = {fs_to_ds.pc[31:28], held.inst.j_fmt.jidx, 2'b00};
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else begin
            if (exp_allowin) begin
                held_valid <= fs_to_ds_valid;
            end
            if (fs_to_ds_valid && exp_allowin) begin
                held <= fs_to_ds;
                accepted <= accepted + 1;
            end
            if (ds_to_es_valid && es_allowin) begin
                delivered <= delivered + 1;
            end
        end
        if (rf_wr.we && rf_wr.waddr != 0) begin
            shadow[rf_wr.waddr] <= rf_wr.wdata;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    a_reset_idle: assert property (@(posedge clk)
        (reset && cycle > 1) |-> (!ds_to_es_valid && !br_bus.taken && ds_allowin))
        else report_mismatch("stage not idle during reset");
    a_out_valid: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid == exp_out_valid) else report_mismatch("ds_to_es_valid");
    a_allowin: assert property (@(posedge clk) disable iff (reset)
        ds_allowin == exp_allowin) else report_mismatch("ds_allowin");
    a_values: assert property (@(posedge clk) disable iff (reset)
        held_valid |-> (ds_to_es.rs_value == exp_val[0] && ds_to_es.rt_value == exp_val[1]))
        else report_mismatch("rs_value or rt_value");
    a_pc_imm: assert property (@(posedge clk) disable iff (reset)
        held_valid |-> (ds_to_es.pc == held.pc && ds_to_es.imm == held.inst.i_fmt.imm))
        else report_mismatch("pc or imm");
    a_ctrl: assert property (@(posedge clk) disable iff (reset)
        (held_valid && dec.chk) |-> (ds_to_es.ctrl.alu_op == dec.alu_op
        && ds_to_es.ctrl.dest == dec.dest && ds_to_es.ctrl.load_op == dec.load_op
        && ds_to_es.ctrl.mem_we == dec.mem_we)) else report_mismatch("ctrl fields or dest");
    a_taken: assert property (@(posedge clk) disable iff (reset)
        br_bus.taken == (held_valid && exp_taken)) else report_mismatch("branch taken");
    a_target: assert property (@(posedge clk) disable iff (reset)
        (held_valid && exp_taken) |-> br_bus.target == exp_target)
        else report_mismatch("branch target");
    a_hold: assert property (@(posedge clk) disable iff (reset)
        (held_valid && $past(held_valid) && !$past(exp_allowin) && $stable(stall_srcs)
        && $stable(fwd_srcs) && !$past(rf_wr.we)) |-> $stable(ds_to_es))
        else report_mismatch("ds_to_es changed while held");

    task automatic issue(input logic [31:0] w);
        logic [31:0] pc;
        pc = next_rand() & 32'hffff_fffc;
        @(posedge clk);
        fs_to_ds_valid <= 1'b1;
        fs_to_ds <= {w, pc};
        @(posedge clk);
        while (!ds_allowin) @(posedge clk);
        fs_to_ds_valid <= 1'b0;
        fs_to_ds.pc <= pc + 32'd4;
    endtask

    task automatic wait_delivered();
        @(posedge clk);
        while (!ds_to_es_valid || !es_allowin) @(posedge clk);
    endtask

    task automatic run_inst(input logic [31:0] w);
        issue(w);
        wait_delivered();
    endtask

    task automatic set_stage(input int k, input logic we, input logic [4:0] dest,
                             input logic valid);
        stall_srcs[k] <= '{we: we, dest: dest};
        fwd_srcs[k] <= '{valid: valid, data: next_rand()};
    endtask

    task automatic clear_srcs();
        @(posedge clk);
        stall_srcs <= '0;
        fwd_srcs <= '0;
    endtask

    initial begin
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic [31:0] w;
        reset = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds = '0;
        es_allowin = 1'b1;
        rf_wr = '0;
        stall_srcs = '0;
        fwd_srcs = '0;
        shadow[0] = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int r = 1; r < 32; r++) begin
            @(posedge clk);
            rf_wr <= '{we: 1'b1, waddr: 5'(r), wdata: next_rand()};
        end
        @(posedge clk);
        rf_wr.we <= 1'b0;

        // no hazards
        run_inst(r_type(rnd_reg(), rnd_reg(), rnd_reg(), 5'd0, 6'h21));
        run_inst(r_type(5'd0, rnd_reg(), rnd_reg(), 5'd0, 6'h21));
        run_inst(i_type(6'h09, rnd_reg(), rnd_reg(), 16'(next_rand())));
        run_inst(r_type(5'd0, rnd_reg(), rnd_reg(), rnd_reg(), 6'h00));
        run_inst(i_type(6'h0f, 5'd0, rnd_reg(), 16'(next_rand())));
        run_inst(i_type(6'h23, rnd_reg(), rnd_reg(), 16'(next_rand())));
        run_inst(i_type(6'h2b, rnd_reg(), rnd_reg(), 16'(next_rand())));
        run_inst(r_type(rnd_reg(), rnd_reg(), 5'd0, 5'd0, 6'h18));
        run_inst(r_type(5'd0, 5'd0, rnd_reg(), 5'd0, 6'h10));
        run_inst({6'h03, 26'(next_rand())});
        run_inst(r_type(rnd_reg(), 5'd0, rnd_reg(), 5'd0, 6'h09));

        // es hit without data, then data arrives
        set_stage(0, 1'b1, 5'd3, 1'b0);
        issue(r_type(5'd3, 5'd4, 5'd7, 5'd0, 6'h21));
        repeat (4) @(posedge clk);
        fwd_srcs[0].valid <= 1'b1;
        wait_delivered();
        clear_srcs();
        // all three hit rt and es has priority
        set_stage(0, 1'b1, 5'd4, 1'b1);
        set_stage(1, 1'b1, 5'd4, 1'b1);
        set_stage(2, 1'b1, 5'd4, 1'b1);
        run_inst(r_type(5'd3, 5'd4, 5'd7, 5'd0, 6'h21));
        clear_srcs();
        // es hit invalid hides a valid ms forward
        set_stage(0, 1'b1, 5'd3, 1'b0);
        set_stage(1, 1'b1, 5'd3, 1'b1);
        issue(r_type(5'd3, 5'd4, 5'd7, 5'd0, 6'h21));
        repeat (3) @(posedge clk);
        fwd_srcs[0].valid <= 1'b1;
        wait_delivered();
        clear_srcs();
        set_stage(1, 1'b1, 5'd4, 1'b1);
        set_stage(2, 1'b1, 5'd4, 1'b1);
        run_inst(r_type(5'd3, 5'd4, 5'd7, 5'd0, 6'h21));
        clear_srcs();
        // r0 and an unused rt never stall
        set_stage(0, 1'b1, 5'd0, 1'b0);
        run_inst(r_type(5'd0, 5'd0, 5'd7, 5'd0, 6'h21));
        clear_srcs();
        set_stage(0, 1'b1, 5'd5, 1'b0);
        run_inst(i_type(6'h09, 5'd3, 5'd5, 16'h0010));
        clear_srcs();

        for (int i = 0; i < 36; i++) begin
            rs = rnd_reg();
            rt = (i / 12 == 1) ? rs : rnd_reg();
            imm = 16'(next_rand());
            case (i % 12)
                0: w = i_type(6'h04, rs, rt, imm);
                1: w = i_type(6'h05, rs, rt, imm);
                2: w = i_type(6'h06, rs, 5'h00, imm);
                3: w = i_type(6'h07, rs, 5'h00, imm);
                4: w = i_type(6'h01, rs, 5'h00, imm);
                5: w = i_type(6'h01, rs, 5'h01, imm);
                6: w = i_type(6'h01, rs, 5'h10, imm);
                7: w = i_type(6'h01, rs, 5'h11, imm);
                8: w = {6'h02, 26'(next_rand())};
                9: w = {6'h03, 26'(next_rand())};
                10: w = r_type(rs, 5'd0, 5'd0, 5'd0, 6'h08);
                default: w = r_type(rs, 5'd0, rnd_reg(), 5'd0, 6'h09);
            endcase
            run_inst(w);
        end

        // execute back-pressure
        es_allowin <= 1'b0;
        issue(i_type(6'h2b, rnd_reg(), rnd_reg(), 16'(next_rand())));
        repeat (4) @(posedge clk);
        es_allowin <= 1'b1;
        wait_delivered();
        repeat (3) @(posedge clk);

        if (accepted != delivered) begin
            errors++;
            $display("%0d instructions accepted but %0d delivered", accepted, delivered);
        end
        $display("errors: %0d, accepted: %0d, delivered: %0d", errors, accepted, delivered);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+include
hdl/decode_pkg.sv
hdl/regfile.sv
hdl/instr_decoder.sv
hdl/hazard_unit.sv
hdl/branch_compare.sv
hdl/id_stage.sv
verif/tb_id_stage.sv

//--- Bender.yml
package:
  name: id_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/decode_pkg.sv
      - hdl/regfile.sv
      - hdl/instr_decoder.sv
      - hdl/hazard_unit.sv
      - hdl/branch_compare.sv
      - hdl/id_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_id_stage.sv
